//--- execCluster.f
rtl/archPkg.sv
rtl/uopPkg.sv
rtl/operandRead.sv
rtl/intAlu.sv
rtl/multiplier.sv
rtl/divider.sv
rtl/writebackMux.sv
rtl/execCluster.sv
testbench/clockGen.sv
testbench/execClusterTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= execClusterTb
FILELIST ?= execCluster.f
OBJDIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal

SRCS := $(wildcard rtl/*.sv testbench/*.sv)
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/execClusterTb.sv
`timescale 1ns/1ns

module execClusterTb;
    import archPkg::*;
    import uopPkg::*;

    localparam int clkPeriod = 8;
    localparam int longWaitLimit = divCycles + 16;
    // op count of all tests rounded up with each op bounded by a worst-case divide
    localparam int numTestOps = 300;
    localparam int worstDivLatency = divCycles + 8;
    localparam int watchdogNs = numTestOps * worstDivLatency * clkPeriod + 2000;

    logic clk;
    logic rst;
    logic flush;
    logic issueValid [numPorts];
    fuKind issueFu [numPorts];
    opField issueOp [numPorts];
    logic [tagWidth-1:0] issueSrcA [numPorts];
    logic [tagWidth-1:0] issueSrcB [numPorts];
    logic [dataWidth-1:0] issueImm [numPorts];
    logic issueUseImm [numPorts];
    logic [tagWidth-1:0] issueTagDst [numPorts];
    logic [nmWidth-1:0] issueNmDst [numPorts];
    logic wbValid [numPorts];
    logic [tagWidth-1:0] wbTag [numPorts];
    logic [nmWidth-1:0] wbNmDst [numPorts];
    logic [dataWidth-1:0] wbResult [numPorts];
    logic divBlock;
    logic mulBlock;

    // expected register file contents
    logic [dataWidth-1:0] regModel [numPhysRegs];
    integer seed;

    // port 1 writebacks still owed during the back-pressure test
    logic [tagWidth-1:0] pendTag [$];
    logic [dataWidth-1:0] pendVal [$];
    logic [dataWidth-1:0] mulExpect;
    logic mulSeen;

    clockGen clockGen_inst (
        .clk(clk)
    );

    execCluster execCluster_inst (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .issueValid(issueValid),
        .issueFu(issueFu),
        .issueOp(issueOp),
        .issueSrcA(issueSrcA),
        .issueSrcB(issueSrcB),
        .issueImm(issueImm),
        .issueUseImm(issueUseImm),
        .issueTagDst(issueTagDst),
        .issueNmDst(issueNmDst),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .wbNmDst(wbNmDst),
        .wbResult(wbResult),
        .divBlock(divBlock),
        .mulBlock(mulBlock)
    );

    task automatic abortRun();
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(input string name, input logic [dataWidth-1:0] actual,
                              input logic [dataWidth-1:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    function automatic opField aluOpField(input aluOp op);
        opField f;
        f = '0;
        f.alu = op;
        return f;
    endfunction

    function automatic opField mdOpField(input logic high, input logic sa, input logic sb);
        opField f;
        f = '0;
        f.md.high = high;
        f.md.signedA = sa;
        f.md.signedB = sb;
        return f;
    endfunction

    // RV32 integer semantics
    function automatic logic [dataWidth-1:0] aluModel(input aluOp op,
            input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
        logic [2*dataWidth-1:0] ext;
        int sh;
        sh = int'(b[4:0]);
        ext = {{dataWidth{a[dataWidth-1]}}, a};
        case (op)
            aluAdd: return a + b;
            aluSub: return a - b;
            aluAnd: return a & b;
            aluOr: return a | b;
            aluXor: return a ^ b;
            aluSll: return a << sh;
            aluSrl: return a >> sh;
            aluSra: begin
                ext = ext >> sh;
                return ext[dataWidth-1:0];
            end
            // differing signs decide by the sign of a
            aluSlt: begin
                if (a[dataWidth-1] != b[dataWidth-1]) begin
                    return dataWidth'(a[dataWidth-1]);
                end
                return dataWidth'(a < b);
            end
            aluSltu: return dataWidth'(a < b);
            default: return '0;
        endcase
    endfunction

    function automatic logic [dataWidth-1:0] mulModel(input logic high, input logic sa,
            input logic sb, input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
        logic [2*dataWidth-1:0] wa;
        logic [2*dataWidth-1:0] wb;
        logic [2*dataWidth-1:0] prod;
        wa = sa ? {{dataWidth{a[dataWidth-1]}}, a} : {{dataWidth{1'b0}}, a};
        wb = sb ? {{dataWidth{b[dataWidth-1]}}, b} : {{dataWidth{1'b0}}, b};
        prod = wa * wb;
        return high ? prod[2*dataWidth-1:dataWidth] : prod[dataWidth-1:0];
    endfunction

    // truncating division where the remainder takes the dividend's sign
    function automatic logic [dataWidth-1:0] divModel(input logic high, input logic sa,
            input logic sb, input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
        longint va;
        longint vb;
        longint q;
        longint r;
        if (b == '0) begin
            return high ? a : '1;
        end
        va = sa ? longint'($signed(a)) : longint'(a);
        vb = sb ? longint'($signed(b)) : longint'(b);
        q = va / vb;
        r = va % vb;
        return high ? dataWidth'(r) : dataWidth'(q);
    endfunction

    task automatic setIssue(input int p, input fuKind fu, input opField op,
            input logic [tagWidth-1:0] srcA, input logic [tagWidth-1:0] srcB,
            input logic [dataWidth-1:0] imm, input logic useImm,
            input logic [tagWidth-1:0] tagDst, input logic [nmWidth-1:0] nmDst);
        issueValid[p] = 1'b1;
        issueFu[p] = fu;
        issueOp[p] = op;
        issueSrcA[p] = srcA;
        issueSrcB[p] = srcB;
        issueImm[p] = imm;
        issueUseImm[p] = useImm;
        issueTagDst[p] = tagDst;
        issueNmDst[p] = nmDst;
    endtask

    task automatic clearIssue(input int p);
        issueValid[p] = 1'b0;
        issueUseImm[p] = 1'b0;
    endtask

    // issues one ALU op and ends in its writeback cycle
    task automatic runAluOp(input int p, input aluOp op, input logic [tagWidth-1:0] srcA,
            input logic [tagWidth-1:0] srcB, input logic [dataWidth-1:0] imm,
            input logic useImm, input logic [tagWidth-1:0] tagDst,
            input logic [nmWidth-1:0] nmDst);
        logic [dataWidth-1:0] bVal;
        logic [dataWidth-1:0] expected;
        bVal = useImm ? imm : regModel[srcB];
        expected = aluModel(op, regModel[srcA], bVal);
        setIssue(p, fuInt, aluOpField(op), srcA, srcB, imm, useImm, tagDst, nmDst);
        @(negedge clk);
        clearIssue(p);
        checkValue($sformatf("wbValid[%0d] one cycle after issue", p), 32'(wbValid[p]), 32'd0);
        @(negedge clk);
        checkValue($sformatf("wbValid[%0d]", p), 32'(wbValid[p]), 32'd1);
        checkValue($sformatf("wbTag[%0d]", p), 32'(wbTag[p]), 32'(tagDst));
        checkValue($sformatf("wbNmDst[%0d]", p), 32'(wbNmDst[p]), 32'(nmDst));
        checkValue($sformatf("wbResult[%0d]", p), wbResult[p], expected);
        if (nmDst != '0) begin
            regModel[tagDst] = expected;
        end
    endtask

    // tag 0 is never written and reads zero
    task automatic loadReg(input int p, input logic [tagWidth-1:0] tag,
                           input logic [dataWidth-1:0] value);
        runAluOp(p, aluAdd, 6'd0, 6'd0, value, 1'b1, tag, 5'd1);
    endtask

    task automatic runLongOp(input int p, input fuKind fu, input opField op,
            input logic [tagWidth-1:0] srcA, input logic [tagWidth-1:0] srcB,
            input logic [tagWidth-1:0] tagDst);
        logic [dataWidth-1:0] expected;
        logic blk;
        int waited;
        if (fu == fuMul) begin
            expected = mulModel(op.md.high, op.md.signedA, op.md.signedB,
                                regModel[srcA], regModel[srcB]);
        end else begin
            expected = divModel(op.md.high, op.md.signedA, op.md.signedB,
                                regModel[srcA], regModel[srcB]);
        end
        setIssue(p, fu, op, srcA, srcB, '0, 1'b0, tagDst, 5'd12);
        @(negedge clk);
        clearIssue(p);
        waited = 0;
        while (!wbValid[p]) begin
            blk = (fu == fuMul) ? mulBlock : divBlock;
            checkValue((fu == fuMul) ? "mulBlock" : "divBlock", 32'(blk), 32'd1);
            if (waited == longWaitLimit) begin
                $display("no writeback on port %0d within %0d cycles of a long op",
                         p, longWaitLimit);
                abortRun();
            end
            @(negedge clk);
            waited++;
        end
        checkValue($sformatf("wbTag[%0d]", p), 32'(wbTag[p]), 32'(tagDst));
        checkValue($sformatf("wbResult[%0d]", p), wbResult[p], expected);
        regModel[tagDst] = expected;
    endtask

    task automatic exerciseAluOps();
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] imm;
        for (int p = 0; p < numPorts; p++) begin
            for (int k = 0; k <= int'(aluSltu); k++) begin
                for (int u = 0; u < 2; u++) begin
                    a = $random(seed);
                    b = $random(seed);
                    imm = $random(seed);
                    loadReg(p, 6'd2, a);
                    loadReg(p, 6'd3, b);
                    runAluOp(p, aluOp'(k), 6'd2, 6'd3, imm, 1'(u), 6'd4, 5'd4);
                end
            end
        end
    endtask

    // each op issues in the writeback cycle of the one before
    task automatic chainDependentOps();
        logic [tagWidth-1:0] prevTag;
        logic [tagWidth-1:0] srcB;
        logic [dataWidth-1:0] imm;
        loadReg(0, 6'd5, $random(seed));
        prevTag = 6'd5;
        for (int i = 0; i < 10; i++) begin
            imm = $random(seed);
            srcB = (i % 3 == 1) ? prevTag : 6'd5;
            runAluOp(i % 2, aluOp'(i), prevTag, srcB, imm, i % 3 == 0, 6'(6 + i), 5'd6);
            prevTag = 6'(6 + i);
        end
    endtask

    task automatic coverMulDivOps();
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        opField op;
        for (int v = 0; v < 8; v++) begin
            op = mdOpField(v[2], v[1], v[0]);
            for (int round = 0; round < 2; round++) begin
                a = $random(seed);
                b = $random(seed);
                // small divisor for a wide quotient
                if (round == 1) begin
                    b = {{(dataWidth-12){b[11]}}, b[11:0]};
                end
                loadReg(1, 6'd10, a);
                loadReg(1, 6'd11, b);
                runLongOp(1, fuMul, op, 6'd10, 6'd11, 6'd12);
                runLongOp(0, fuDiv, op, 6'd10, 6'd11, 6'd12);
            end
            runLongOp(0, fuDiv, op, 6'd10, 6'd0, 6'd12);
        end
        // most negative over minus one
        loadReg(0, 6'd10, 32'h8000_0000);
        loadReg(0, 6'd11, 32'hffff_ffff);
        runLongOp(0, fuDiv, mdOpField(1'b0, 1'b1, 1'b1), 6'd10, 6'd11, 6'd12);
        runLongOp(0, fuDiv, mdOpField(1'b1, 1'b1, 1'b1), 6'd10, 6'd11, 6'd12);
    endtask

    task automatic collectWriteback();
        if (wbValid[1]) begin
            if (pendTag.size() > 0) begin
                checkValue("wbTag[1]", 32'(wbTag[1]), 32'(pendTag.pop_front()));
                checkValue("wbResult[1]", wbResult[1], pendVal.pop_front());
            end else if (!mulSeen) begin
                checkValue("wbTag[1]", 32'(wbTag[1]), 32'd13);
                checkValue("wbResult[1]", wbResult[1], mulExpect);
                mulSeen = 1'b1;
            end else begin
                $display("unexpected extra writeback on port 1 with tag %0d", wbTag[1]);
                abortRun();
            end
        end
    endtask

    task automatic stallMultiply();
        logic [dataWidth-1:0] imm;
        int waited;
        loadReg(1, 6'd10, $random(seed));
        loadReg(1, 6'd11, $random(seed));
        mulExpect = mulModel(1'b0, 1'b1, 1'b1, regModel[10], regModel[11]);
        mulSeen = 1'b0;
        setIssue(1, fuMul, mdOpField(1'b0, 1'b1, 1'b1), 6'd10, 6'd11, '0, 1'b0, 6'd13, 5'd13);
        @(negedge clk);
        // alu stream keeps the slot busy past the multiply's finish
        for (int i = 0; i < 8; i++) begin
            collectWriteback();
            imm = $random(seed);
            setIssue(1, fuInt, aluOpField(aluAdd), 6'd10, 6'd0, imm, 1'b1, 6'(20 + i), 5'd20);
            pendTag.push_back(6'(20 + i));
            pendVal.push_back(regModel[10] + imm);
            regModel[20 + i] = regModel[10] + imm;
            @(negedge clk);
        end
        clearIssue(1);
        waited = 0;
        while (!mulSeen) begin
            if (waited == longWaitLimit) begin
                $display("multiply result never written back after the alu stream");
                abortRun();
            end
            collectWriteback();
            @(negedge clk);
            waited++;
        end
        regModel[13] = mulExpect;
        repeat (4) begin
            checkValue("wbValid[1]", 32'(wbValid[1]), 32'd0);
            @(negedge clk);
        end
    endtask

    task automatic dropNoDestWrite();
        logic [dataWidth-1:0] v;
        v = $random(seed);
        loadReg(0, 6'd30, v);
        runAluOp(0, aluAdd, 6'd0, 6'd0, ~v, 1'b1, 6'd30, 5'd0);
        // first read overlaps that writeback and the second comes from the array
        runAluOp(1, aluAdd, 6'd30, 6'd0, '0, 1'b1, 6'd31, 5'd31);
        runAluOp(1, aluAdd, 6'd30, 6'd0, '0, 1'b1, 6'd31, 5'd31);
    endtask

    task automatic flushInFlight();
        logic [dataWidth-1:0] imm;
        loadReg(0, 6'd40, $random(seed));
        loadReg(1, 6'd41, $random(seed));
        loadReg(0, 6'd10, $random(seed));
        loadReg(1, 6'd11, $random(seed));
        imm = $random(seed);
        setIssue(0, fuDiv, mdOpField(1'b0, 1'b1, 1'b1), 6'd10, 6'd11, '0, 1'b0, 6'd40, 5'd1);
        @(negedge clk);
        clearIssue(0);
        setIssue(1, fuInt, aluOpField(aluXor), 6'd10, 6'd0, imm, 1'b1, 6'd41, 5'd1);
        @(negedge clk);
        clearIssue(1);
        checkValue("divBlock", 32'(divBlock), 32'd1);
        flush = 1'b1;
        setIssue(0, fuInt, aluOpField(aluAdd), 6'd10, 6'd0, imm, 1'b1, 6'd42, 5'd1);
        @(negedge clk);
        flush = 1'b0;
        clearIssue(0);
        for (int i = 0; i < divCycles + 8; i++) begin
            checkValue("wbValid[0]", 32'(wbValid[0]), 32'd0);
            checkValue("wbValid[1]", 32'(wbValid[1]), 32'd0);
            checkValue("divBlock", 32'(divBlock), 32'd0);
            @(negedge clk);
        end
        runAluOp(0, aluAdd, 6'd40, 6'd0, '0, 1'b1, 6'd50, 5'd1);
        runAluOp(1, aluAdd, 6'd41, 6'd0, '0, 1'b1, 6'd50, 5'd1);
        runAluOp(0, aluAdd, 6'd42, 6'd0, '0, 1'b1, 6'd50, 5'd1);
    endtask

    initial begin
        seed = 32'he72f;
        rst = 1'b1;
        flush = 1'b0;
        for (int p = 0; p < numPorts; p++) begin
            issueValid[p] = 1'b0;
            issueFu[p] = fuInt;
            issueOp[p] = '0;
            issueSrcA[p] = '0;
            issueSrcB[p] = '0;
            issueImm[p] = '0;
            issueUseImm[p] = 1'b0;
            issueTagDst[p] = '0;
            issueNmDst[p] = '0;
        end
        for (int i = 0; i < numPhysRegs; i++) begin
            regModel[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        exerciseAluOps();
        chainDependentOps();
        coverMulDivOps();
        stallMultiply();
        dropNoDestWrite();
        flushInFlight();
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired after %0d ns, the tests did not finish", watchdogNs);
        abortRun();
    end

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ns

module clockGen (
    output logic clk
);
    // 8 ns period
    localparam int halfPeriod = 4;

    initial begin
        clk = 1'b0;
        forever begin
            #halfPeriod clk = ~clk;
        end
    end

endmodule

//--- rtl/execCluster.sv
`timescale 1ns/1ns

module execCluster (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic issueValid [archPkg::numPorts],
    input  uopPkg::fuKind issueFu [archPkg::numPorts],
    input  uopPkg::opField issueOp [archPkg::numPorts],
    input  logic [archPkg::tagWidth-1:0] issueSrcA [archPkg::numPorts],
    input  logic [archPkg::tagWidth-1:0] issueSrcB [archPkg::numPorts],
    input  logic [archPkg::dataWidth-1:0] issueImm [archPkg::numPorts],
    input  logic issueUseImm [archPkg::numPorts],
    input  logic [archPkg::tagWidth-1:0] issueTagDst [archPkg::numPorts],
    input  logic [archPkg::nmWidth-1:0] issueNmDst [archPkg::numPorts],
    output logic wbValid [archPkg::numPorts],
    output logic [archPkg::tagWidth-1:0] wbTag [archPkg::numPorts],
    output logic [archPkg::nmWidth-1:0] wbNmDst [archPkg::numPorts],
    output logic [archPkg::dataWidth-1:0] wbResult [archPkg::numPorts],
    output logic divBlock,
    output logic mulBlock
);
    import archPkg::*;
    import uopPkg::*;

    logic exValid [numPorts];
    fuKind exFu [numPorts];
    opField exOp [numPorts];
    logic [dataWidth-1:0] exA [numPorts];
    logic [dataWidth-1:0] exB [numPorts];
    logic [tagWidth-1:0] exTagDst [numPorts];
    logic [nmWidth-1:0] exNmDst [numPorts];
    logic [dataWidth-1:0] aluResult [numPorts];

    // long unit per port, divider on 0 and multiplier on 1
    logic longValid [numPorts];
    logic [tagWidth-1:0] longTag [numPorts];
    logic [nmWidth-1:0] longNmDst [numPorts];
    logic [dataWidth-1:0] longResult [numPorts];
    logic accept [numPorts];

    operandRead operandRead_inst (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .issueValid(issueValid),
        .issueFu(issueFu),
        .issueOp(issueOp),
        .issueSrcA(issueSrcA),
        .issueSrcB(issueSrcB),
        .issueImm(issueImm),
        .issueUseImm(issueUseImm),
        .issueTagDst(issueTagDst),
        .issueNmDst(issueNmDst),
        .wbValid(wbValid),
        .wbTag(wbTag),
        .wbNmDst(wbNmDst),
        .wbResult(wbResult),
        .exValid(exValid),
        .exFu(exFu),
        .exOp(exOp),
        .exA(exA),
        .exB(exB),
        .exTagDst(exTagDst),
        .exNmDst(exNmDst)
    );

    divider divider_inst (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .exValid(exValid[0]),
        .exFu(exFu[0]),
        .exOp(exOp[0]),
        .exA(exA[0]),
        .exB(exB[0]),
        .exTagDst(exTagDst[0]),
        .exNmDst(exNmDst[0]),
        .accept(accept[0]),
        .resultValid(longValid[0]),
        .resultTag(longTag[0]),
        .resultNmDst(longNmDst[0]),
        .result(longResult[0]),
        .divBlock(divBlock)
    );

    multiplier multiplier_inst (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .exValid(exValid[1]),
        .exFu(exFu[1]),
        .exOp(exOp[1]),
        .exA(exA[1]),
        .exB(exB[1]),
        .exTagDst(exTagDst[1]),
        .exNmDst(exNmDst[1]),
        .accept(accept[1]),
        .resultValid(longValid[1]),
        .resultTag(longTag[1]),
        .resultNmDst(longNmDst[1]),
        .result(longResult[1]),
        .mulBlock(mulBlock)
    );

    for (genvar p = 0; p < numPorts; p++) begin : portGen
        intAlu intAlu_inst (
            .op(exOp[p].alu),
            .a(exA[p]),
            .b(exB[p]),
            .result(aluResult[p])
        );

        writebackMux writebackMux_inst (
            .clk(clk),
            .rst(rst),
            .flush(flush),
            .exValid(exValid[p]),
            .exFu(exFu[p]),
            .exTagDst(exTagDst[p]),
            .exNmDst(exNmDst[p]),
            .aluResult(aluResult[p]),
            .longValid(longValid[p]),
            .longTag(longTag[p]),
            .longNmDst(longNmDst[p]),
            .longResult(longResult[p]),
            .accept(accept[p]),
            .wbValid(wbValid[p]),
            .wbTag(wbTag[p]),
            .wbNmDst(wbNmDst[p]),
            .wbResult(wbResult[p])
        );
    end

endmodule

//--- rtl/writebackMux.sv
`timescale 1ns/1ns

module writebackMux (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic exValid,
    input  uopPkg::fuKind exFu,
    input  logic [archPkg::tagWidth-1:0] exTagDst,
    input  logic [archPkg::nmWidth-1:0] exNmDst,
    input  logic [archPkg::dataWidth-1:0] aluResult,
    input  logic longValid,
    input  logic [archPkg::tagWidth-1:0] longTag,
    input  logic [archPkg::nmWidth-1:0] longNmDst,
    input  logic [archPkg::dataWidth-1:0] longResult,
    output logic accept,
    output logic wbValid,
    output logic [archPkg::tagWidth-1:0] wbTag,
    output logic [archPkg::nmWidth-1:0] wbNmDst,
    output logic [archPkg::dataWidth-1:0] wbResult
);
    import uopPkg::*;

    logic aluSel;

    // alu has no storage so it always wins the slot
    assign aluSel = exValid && exFu == fuInt;
    assign accept = longValid && !aluSel;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= aluSel || longValid;
        end
    end

    always_ff @(posedge clk) begin
        if (aluSel) begin
            wbTag <= exTagDst;
            wbNmDst <= exNmDst;
            wbResult <= aluResult;
        end else begin
            wbTag <= longTag;
            wbNmDst <= longNmDst;
            wbResult <= longResult;
        end
    end

endmodule

//--- rtl/divider.sv
`timescale 1ns/1ns

module divider (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic exValid,
    input  uopPkg::fuKind exFu,
    input  uopPkg::opField exOp,
    input  logic [archPkg::dataWidth-1:0] exA,
    input  logic [archPkg::dataWidth-1:0] exB,
    input  logic [archPkg::tagWidth-1:0] exTagDst,
    input  logic [archPkg::nmWidth-1:0] exNmDst,
    input  logic accept,
    output logic resultValid,
    output logic [archPkg::tagWidth-1:0] resultTag,
    output logic [archPkg::nmWidth-1:0] resultNmDst,
    output logic [archPkg::dataWidth-1:0] result,
    output logic divBlock
);
    import archPkg::*;
    import uopPkg::*;

    localparam int cntWidth = $clog2(divCycles);

    logic start;
    logic busy;
    logic [cntWidth-1:0] cnt;
    logic negA;
    logic negB;
    logic [dataWidth-1:0] magA;
    logic [dataWidth-1:0] magB;
    logic [dataWidth-1:0] dividend;
    logic [dataWidth-1:0] divisorMag;
    logic [dataWidth-1:0] quo;
    logic [dataWidth-1:0] rem;
    logic negQuo;
    logic negRem;
    logic divZero;
    logic high;
    logic [dataWidth:0] shifted;
    logic [dataWidth:0] diff;

    assign start = exValid && exFu == fuDiv;
    assign negA = exOp.md.signedA && exA[dataWidth-1];
    assign negB = exOp.md.signedB && exB[dataWidth-1];
    assign magA = negA ? -exA : exA;
    assign magB = negB ? -exB : exB;

    // one restoring step per cycle, quotient bits shift in at the bottom
    assign shifted = {rem, quo[dataWidth-1]};
    assign diff = shifted - {1'b0, divisorMag};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= 1'b0;
            resultValid <= 1'b0;
            cnt <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt <= cntWidth'(divCycles - 1);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
                resultValid <= 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (accept) begin
            resultValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dividend <= exA;
            divisorMag <= magB;
            quo <= magA;
            rem <= '0;
            negQuo <= negA ^ negB;
            negRem <= negA;
            divZero <= exB == '0;
            high <= exOp.md.high;
            resultTag <= exTagDst;
            resultNmDst <= exNmDst;
        end else if (busy) begin
            if (diff[dataWidth]) begin
                rem <= shifted[dataWidth-1:0];
                quo <= {quo[dataWidth-2:0], 1'b0};
            end else begin
                rem <= diff[dataWidth-1:0];
                quo <= {quo[dataWidth-2:0], 1'b1};
            end
        end
    end

    // most negative / -1 falls out of the magnitude path as dividend, rem 0
    always_comb begin
        if (divZero) begin
            result = high ? dividend : '1;
        end else if (high) begin
            result = negRem ? -rem : rem;
        end else begin
            result = negQuo ? -quo : quo;
        end
    end

    assign divBlock = busy || resultValid || start;

endmodule

//--- rtl/multiplier.sv
`timescale 1ns/1ns

module multiplier (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic exValid,
    input  uopPkg::fuKind exFu,
    input  uopPkg::opField exOp,
    input  logic [archPkg::dataWidth-1:0] exA,
    input  logic [archPkg::dataWidth-1:0] exB,
    input  logic [archPkg::tagWidth-1:0] exTagDst,
    input  logic [archPkg::nmWidth-1:0] exNmDst,
    input  logic accept,
    output logic resultValid,
    output logic [archPkg::tagWidth-1:0] resultTag,
    output logic [archPkg::nmWidth-1:0] resultNmDst,
    output logic [archPkg::dataWidth-1:0] result,
    output logic mulBlock
);
    import archPkg::*;
    import uopPkg::*;

    localparam int cntWidth = $clog2(mulCycles);

    logic start;
    logic busy;
    logic [cntWidth-1:0] cnt;
    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] srcB;
    logic aSigned;
    logic bSigned;
    logic high;
    logic [2*dataWidth-1:0] product;

    assign start = exValid && exFu == fuMul;

    // extra top bit per operand gives the mixed-sign variants
    assign product = $signed({aSigned && srcA[dataWidth-1], srcA})
        * $signed({bSigned && srcB[dataWidth-1], srcB});

    // capture is one cycle, so count down from mulCycles-2
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= 1'b0;
            resultValid <= 1'b0;
            cnt <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt <= cntWidth'(mulCycles - 2);
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;
                resultValid <= 1'b1;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (accept) begin
            resultValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            srcA <= exA;
            srcB <= exB;
            aSigned <= exOp.md.signedA;
            bSigned <= exOp.md.signedB;
            high <= exOp.md.high;
            resultTag <= exTagDst;
            resultNmDst <= exNmDst;
        end
        if (busy && cnt == '0) begin
            result <= high ? product[2*dataWidth-1:dataWidth] : product[dataWidth-1:0];
        end
    end

    assign mulBlock = busy || resultValid || start;

endmodule

//--- rtl/intAlu.sv
`timescale 1ns/1ns

module intAlu (
    input  uopPkg::aluOp op,
    input  logic [archPkg::dataWidth-1:0] a,
    input  logic [archPkg::dataWidth-1:0] b,
    output logic [archPkg::dataWidth-1:0] result
);
    import archPkg::*;
    import uopPkg::*;

    logic [4:0] shamt;
    logic lessSigned;
    logic lessUnsigned;

    assign shamt = b[4:0];
    assign lessSigned = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            aluAdd:
                result = a + b;
            aluSub:
                result = a - b;
            aluAnd:
                result = a & b;
            aluOr:
                result = a | b;
            aluXor:
                result = a ^ b;
            aluSll:
                result = a << shamt;
            aluSrl:
                result = a >> shamt;
            aluSra:
                result = $signed(a) >>> shamt;
            aluSlt:
                result = {{(dataWidth-1){1'b0}}, lessSigned};
            aluSltu:
                result = {{(dataWidth-1){1'b0}}, lessUnsigned};
            default:
                result = '0;
        endcase
    end

endmodule

//--- rtl/operandRead.sv
`timescale 1ns/1ns

module operandRead (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic issueValid [archPkg::numPorts],
    input  uopPkg::fuKind issueFu [archPkg::numPorts],
    input  uopPkg::opField issueOp [archPkg::numPorts],
    input  logic [archPkg::tagWidth-1:0] issueSrcA [archPkg::numPorts],
    input  logic [archPkg::tagWidth-1:0] issueSrcB [archPkg::numPorts],
    input  logic [archPkg::dataWidth-1:0] issueImm [archPkg::numPorts],
    input  logic issueUseImm [archPkg::numPorts],
    input  logic [archPkg::tagWidth-1:0] issueTagDst [archPkg::numPorts],
    input  logic [archPkg::nmWidth-1:0] issueNmDst [archPkg::numPorts],
    input  logic wbValid [archPkg::numPorts],
    input  logic [archPkg::tagWidth-1:0] wbTag [archPkg::numPorts],
    input  logic [archPkg::nmWidth-1:0] wbNmDst [archPkg::numPorts],
    input  logic [archPkg::dataWidth-1:0] wbResult [archPkg::numPorts],
    output logic exValid [archPkg::numPorts],
    output uopPkg::fuKind exFu [archPkg::numPorts],
    output uopPkg::opField exOp [archPkg::numPorts],
    output logic [archPkg::dataWidth-1:0] exA [archPkg::numPorts],
    output logic [archPkg::dataWidth-1:0] exB [archPkg::numPorts],
    output logic [archPkg::tagWidth-1:0] exTagDst [archPkg::numPorts],
    output logic [archPkg::nmWidth-1:0] exNmDst [archPkg::numPorts]
);
    import archPkg::*;

    logic [dataWidth-1:0] regFile [numPhysRegs];
    logic wbWrite [numPorts];
    logic [dataWidth-1:0] opA [numPorts];
    logic [dataWidth-1:0] opB [numPorts];

    // results without an architectural destination are dropped
    always_comb begin
        for (int w = 0; w < numPorts; w++) begin
            wbWrite[w] = wbValid[w] && (wbNmDst[w] != '0);
        end
    end

    // cleared so every tag reads zero until first written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numPhysRegs; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            for (int w = 0; w < numPorts; w++) begin
                if (wbWrite[w]) begin
                    regFile[wbTag[w]] <= wbResult[w];
                end
            end
        end
    end

    // read plus bypass, higher port wins like the write order above
    always_comb begin
        for (int p = 0; p < numPorts; p++) begin
            opA[p] = regFile[issueSrcA[p]];
            opB[p] = regFile[issueSrcB[p]];
            for (int w = 0; w < numPorts; w++) begin
                if (wbWrite[w] && wbTag[w] == issueSrcA[p]) begin
                    opA[p] = wbResult[w];
                end
                if (wbWrite[w] && wbTag[w] == issueSrcB[p]) begin
                    opB[p] = wbResult[w];
                end
            end
            if (issueUseImm[p]) begin
                opB[p] = issueImm[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < numPorts; p++) begin
            if (rst || flush) begin
                exValid[p] <= 1'b0;
            end else begin
                exValid[p] <= issueValid[p];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < numPorts; p++) begin
            exFu[p] <= issueFu[p];
            exOp[p] <= issueOp[p];
            exA[p] <= opA[p];
            exB[p] <= opB[p];
            exTagDst[p] <= issueTagDst[p];
            exNmDst[p] <= issueNmDst[p];
        end
    end

endmodule

//--- rtl/uopPkg.sv
package uopPkg;

    typedef enum logic [1:0] {
        fuInt = 2'd0,
        fuMul = 2'd1,
        fuDiv = 2'd2
    } fuKind;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSrl  = 4'd6,
        aluSra  = 4'd7,
        aluSlt  = 4'd8,
        aluSltu = 4'd9
    } aluOp;

    // high picks the upper product half, or the remainder for a divide
    typedef struct packed {
        logic spare;
        logic high;
        logic signedA;
        logic signedB;
    } mulDivOp;

    // same 4 bits, read as aluOp by the ALU and as mulDivOp by mul/div
    typedef union packed {
        aluOp alu;
        mulDivOp md;
    } opField;

endpackage

//--- rtl/archPkg.sv
package archPkg;

    // datapath widths
    localparam int dataWidth = 32;
    localparam int tagWidth = 6;
    localparam int nmWidth = 5;

    // one entry per physical tag
    localparam int numPhysRegs = 64;

    localparam int numPorts = 2;

    // long-latency units
    localparam int mulCycles = 4;
    localparam int divCycles = 32;

endpackage
